// File: verilog/link_test_pkg.sv
`default_nettype none

package link_test_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////////////////////

	// One link word, as sent by the transceiver
	typedef logic [15:0] lane_word_t;

	// Wishbone side
	typedef logic [31:0] wb_data_t;
	typedef logic [11:0] wb_addr_t;

	// Per-lane error count, saturating
	typedef logic [15:0] err_count_t;

	// Low byte of a comma word (K28.5)
	localparam logic [7:0] COMMA_CHAR = 8'hBC;

	// Word index inside one capture window
	localparam int CAP_IDX_W = 6;

	// Address map allows this many lanes at most
	localparam int MAX_LANES = 4;

	////////////////////////////////////////////////////////////////////////////
	// Address map, byte addresses
	////////////////////////////////////////////////////////////////////////////

	localparam wb_addr_t ADDR_CTRL        = 12'h000;
	localparam wb_addr_t ADDR_STATUS      = 12'h004;
	// Lane n count at base + 4n
	localparam wb_addr_t ADDR_ERRCNT_BASE = 12'h010;
	// Lane n window at base + 0x100 * n
	localparam wb_addr_t ADDR_CAP_BASE    = 12'h800;

endpackage

`default_nettype wire

// File: verilog/lane_pattern_gen.sv
`timescale 1ns/1ns
`default_nettype none

// Counting test stream for one lane
module lane_pattern_gen
	import link_test_pkg::*;
(
	input  logic       CLK,
	input  logic       rst_n_i,
	output lane_word_t tx_word_o,
	output logic       tx_k_o
);

	lane_word_t word_q;

	////////////////////////////////////////////////////////////////////////////
	// Word counter
	////////////////////////////////////////////////////////////////////////////

	// Zero right after reset, then +1 per clock
	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			word_q <= '0;
		end else begin
			// Wraps at 16 bits
			word_q <= lane_word_t'(word_q + 16'd1);
		end
	end

	assign tx_word_o = word_q;

	// Comma once every 256 words
	assign tx_k_o = (word_q[7:0] == COMMA_CHAR);

endmodule

`default_nettype wire

// File: verilog/lane_checker.sv
`timescale 1ns/1ns
`default_nettype none

// Receive sequence checker for one lane
module lane_checker
	import link_test_pkg::*;
(
	input  logic       CLK,
	input  logic       rst_n_i,
	input  lane_word_t rx_word_i,
	input  logic       clr_i,
	output logic       err_o,
	output err_count_t err_count_o
);

	lane_word_t prev_q;
	lane_word_t expect_w;
	logic       first_q;
	logic       mismatch_w;
	logic       err_q;
	err_count_t count_q;

	// Next word should be previous + 1
	assign expect_w = lane_word_t'(prev_q + 16'd1);

	// No reference yet for the very first word
	assign mismatch_w = !first_q && (rx_word_i != expect_w);

	// Last received word
	always_ff @(posedge CLK) begin
		prev_q <= rx_word_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// Error pulse and counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			first_q <= 1'b1;
			err_q   <= 1'b0;
			count_q <= '0;
		end else begin
			first_q <= 1'b0;
			err_q   <= mismatch_w;
			// Clear wins over a same-cycle error
			if (clr_i) begin
				count_q <= '0;
			end else if (mismatch_w && (count_q != '1)) begin
				count_q <= err_count_t'(count_q + 16'd1);
			end
		end
	end

	assign err_o       = err_q;
	assign err_count_o = count_q;

	// Saturated count only leaves all ones via a clear
	a_count_sat: assert property (@(posedge CLK) disable iff (!rst_n_i)
		((count_q == '1) && !clr_i) |=> (count_q != '0));

endmodule

`default_nettype wire

// File: verilog/capture_ram.sv
`timescale 1ns/1ns
`default_nettype none

// Armed block capture of received words for one lane
module capture_ram
	import link_test_pkg::*;
#(
	parameter int CAP_DEPTH = 64
) (
	input  logic                 CLK,
	input  logic                 rst_n_i,
	input  lane_word_t           rx_word_i,
	input  logic                 arm_i,
	input  logic [CAP_IDX_W-1:0] rd_addr_i,
	output lane_word_t           rd_data_o,
	output logic                 done_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FILLING,
		S_FULL
	} cap_state_t;

	// One extra bit so the pointer can be compared against CAP_DEPTH
	localparam logic [CAP_IDX_W:0] LAST_IDX = (CAP_IDX_W + 1)'(CAP_DEPTH - 1);

	cap_state_t           state_q;
	logic [CAP_IDX_W:0]   wr_ptr_q;
	lane_word_t           mem [CAP_DEPTH];
	lane_word_t           rd_data_q;

	////////////////////////////////////////////////////////////////////////////
	// Capture FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			state_q  <= S_IDLE;
			wr_ptr_q <= '0;
		end else if (arm_i) begin
			// Restart from index 0, any state
			state_q  <= S_FILLING;
			wr_ptr_q <= '0;
		end else begin
			case (state_q)
				S_FILLING: begin
					if (wr_ptr_q == LAST_IDX) begin
						state_q <= S_FULL;
					end else begin
						wr_ptr_q <= wr_ptr_q + 1'b1;
					end
				end
				// Stay until the next arm
				S_FULL:  state_q <= S_FULL;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// One word per clock while filling
	always_ff @(posedge CLK) begin
		if ((state_q == S_FILLING) && !arm_i) begin
			mem[wr_ptr_q[CAP_IDX_W-1:0]] <= rx_word_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus-side read port
	////////////////////////////////////////////////////////////////////////////

	// Data one clock after the address
	always_ff @(posedge CLK) begin
		rd_data_q <= mem[rd_addr_i];
	end

	assign rd_data_o = rd_data_q;
	assign done_o    = (state_q == S_FULL);

	// Pointer stays inside the buffer for the whole fill
	a_ptr_range: assert property (@(posedge CLK) disable iff (!rst_n_i)
		(state_q == S_FILLING) |-> (wr_ptr_q < CAP_DEPTH));

endmodule

`default_nettype wire

// File: verilog/led_stretch.sv
`timescale 1ns/1ns
`default_nettype none

// Makes single-cycle error pulses visible on an LED
module led_stretch #(
	parameter int LED_HOLD = 16
) (
	input  logic CLK,
	input  logic rst_n_i,
	input  logic trig_i,
	output logic led_o
);

	localparam int HOLD_W = $clog2(LED_HOLD + 1);

	logic [HOLD_W-1:0] hold_q;

	////////////////////////////////////////////////////////////////////////////
	// Retriggerable hold timer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			hold_q <= '0;
		end else if (trig_i) begin
			// Every pulse restarts the full hold time
			hold_q <= HOLD_W'(LED_HOLD);
		end else if (hold_q != '0) begin
			hold_q <= hold_q - 1'b1;
		end
	end

	// Lit while time is left
	assign led_o = (hold_q != '0);

endmodule

`default_nettype wire

// File: verilog/link_regs.sv
`timescale 1ns/1ns
`default_nettype none

// Wishbone classic slave with control, status, counts and capture windows
module link_regs
	import link_test_pkg::*;
#(
	parameter int NUM_LANES = 2,
	parameter int CAP_DEPTH = 64
) (
	input  logic                              CLK,
	input  logic                              rst_n_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_we_i,
	input  wb_addr_t                          wb_adr_i,
	input  wb_data_t                          wb_dat_i,
	output wb_data_t                          wb_dat_o,
	output logic                              wb_ack_o,
	output logic [NUM_LANES-1:0]              arm_o,
	output logic [NUM_LANES-1:0]              clr_o,
	output logic [CAP_IDX_W-1:0]              cap_rd_addr_o,
	input  lane_word_t [NUM_LANES-1:0]        cap_rd_data_i,
	input  logic [NUM_LANES-1:0]              done_i,
	input  logic [NUM_LANES-1:0]              led_i,
	input  err_count_t [NUM_LANES-1:0]        err_count_i
);

	logic                         ack_q;
	logic                         req_w;
	logic                         wr_en_w;
	logic [NUM_LANES-1:0]         ctrl_q;
	logic [NUM_LANES-1:0]         arm_q;
	logic [NUM_LANES-1:0]         clr_q;
	logic                         ctrl_hit;
	logic                         status_hit;
	logic [NUM_LANES-1:0]         errcnt_hit;
	logic                         cap_hit;
	logic [$clog2(MAX_LANES)-1:0] cap_lane;
	wb_data_t                     rd_data;

	// New request, only while ack is low
	assign req_w   = wb_cyc_i && wb_stb_i && !ack_q;
	assign wr_en_w = req_w && wb_we_i;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	// Capture window lane from address bits 9:8
	assign cap_lane = wb_adr_i[9:8];

	always_comb begin
		ctrl_hit   = (wb_adr_i == ADDR_CTRL);
		status_hit = (wb_adr_i == ADDR_STATUS);
		for (int n = 0; n < NUM_LANES; n++) begin
			errcnt_hit[n] = (wb_adr_i == wb_addr_t'(ADDR_ERRCNT_BASE + 4 * n));
		end
		// Beyond the last lane or past the buffer end reads zero
		cap_hit = (wb_adr_i[11:10] == ADDR_CAP_BASE[11:10])
			&& (cap_lane < NUM_LANES)
			&& (wb_adr_i[7:2] < CAP_DEPTH);
	end

	// RAM output is valid during the ack cycle
	assign cap_rd_addr_o = wb_adr_i[7:2];

	////////////////////////////////////////////////////////////////////////////
	// Ack, control register and strobes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n_i) begin
			ack_q  <= 1'b0;
			ctrl_q <= '0;
			arm_q  <= '0;
			clr_q  <= '0;
		end else begin
			// Fixed single-cycle ack
			ack_q <= req_w;
			arm_q <= '0;
			clr_q <= '0;
			if (wr_en_w && ctrl_hit) begin
				ctrl_q <= wb_dat_i[NUM_LANES-1:0];
				// Arm on a 0 to 1 run bit
				arm_q  <= wb_dat_i[NUM_LANES-1:0] & ~ctrl_q;
			end
			// Any value written clears the count
			if (wr_en_w) begin
				clr_q <= errcnt_hit;
			end
		end
	end

	assign wb_ack_o = ack_q;
	assign arm_o    = arm_q;
	assign clr_o    = clr_q;

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_data = '0;
		if (ctrl_hit) begin
			rd_data[NUM_LANES-1:0] = ctrl_q;
		end
		if (status_hit) begin
			rd_data[NUM_LANES-1:0]    = done_i;
			rd_data[16 +: NUM_LANES]  = led_i;
		end
		for (int n = 0; n < NUM_LANES; n++) begin
			if (errcnt_hit[n]) begin
				rd_data[15:0] = err_count_i[n];
			end
		end
		// Word sits in the low half
		if (cap_hit) begin
			rd_data[15:0] = cap_rd_data_i[cap_lane];
		end
	end

	assign wb_dat_o = rd_data;

	// One ack per request, never back to back
	a_ack_single: assert property (@(posedge CLK) disable iff (!rst_n_i)
		wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

// File: verilog/link_test_top.sv
`timescale 1ns/1ns
`default_nettype none

// Serial link test core: register block plus per-lane logic
module link_test_top
	import link_test_pkg::*;
#(
	parameter int NUM_LANES = 2,
	parameter int CAP_DEPTH = 64,
	parameter int LED_HOLD  = 16
) (
	input  logic                       CLK,
	input  logic                       rst_n_i,
	// Wishbone slave
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	input  logic                       wb_we_i,
	input  wb_addr_t                   wb_adr_i,
	input  wb_data_t                   wb_dat_i,
	output wb_data_t                   wb_dat_o,
	output logic                       wb_ack_o,
	// Lanes, loopback is outside the chip
	output lane_word_t [NUM_LANES-1:0] lane_tx_o,
	output logic [NUM_LANES-1:0]       lane_tx_k_o,
	input  lane_word_t [NUM_LANES-1:0] lane_rx_i,
	output logic [NUM_LANES-1:0]       led_o
);

	logic [NUM_LANES-1:0]       arm;
	logic [NUM_LANES-1:0]       clr;
	logic [NUM_LANES-1:0]       done;
	logic [NUM_LANES-1:0]       err;
	err_count_t [NUM_LANES-1:0] err_count;
	lane_word_t [NUM_LANES-1:0] cap_rd_data;
	logic [CAP_IDX_W-1:0]       cap_rd_addr;

	////////////////////////////////////////////////////////////////////////////
	// Register block
	////////////////////////////////////////////////////////////////////////////

	link_regs #(
		.NUM_LANES (NUM_LANES),
		.CAP_DEPTH (CAP_DEPTH)
	) i_link_regs (
		.CLK           (CLK),
		.rst_n_i       (rst_n_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.arm_o         (arm),
		.clr_o         (clr),
		.cap_rd_addr_o (cap_rd_addr),
		.cap_rd_data_i (cap_rd_data),
		.done_i        (done),
		.led_i         (led_o),
		.err_count_i   (err_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// Per-lane logic
	////////////////////////////////////////////////////////////////////////////

	for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
		lane_pattern_gen i_gen (
			.CLK       (CLK),
			.rst_n_i   (rst_n_i),
			.tx_word_o (lane_tx_o[n]),
			.tx_k_o    (lane_tx_k_o[n])
		);

		// Checker and capture see the same rx word
		lane_checker i_checker (
			.CLK         (CLK),
			.rst_n_i     (rst_n_i),
			.rx_word_i   (lane_rx_i[n]),
			.clr_i       (clr[n]),
			.err_o       (err[n]),
			.err_count_o (err_count[n])
		);

		capture_ram #(
			.CAP_DEPTH (CAP_DEPTH)
		) i_capture (
			.CLK       (CLK),
			.rst_n_i   (rst_n_i),
			.rx_word_i (lane_rx_i[n]),
			.arm_i     (arm[n]),
			.rd_addr_i (cap_rd_addr),
			.rd_data_o (cap_rd_data[n]),
			.done_o    (done[n])
		);

		led_stretch #(
			.LED_HOLD (LED_HOLD)
		) i_led (
			.CLK     (CLK),
			.rst_n_i (rst_n_i),
			.trig_i  (err[n]),
			.led_o   (led_o[n])
		);
	end

endmodule

`default_nettype wire

// File: sim/tb_link_test.sv
`timescale 1ns/1ns
`default_nettype none

module tb_link_test
	import link_test_pkg::*;
();

	// DUT defaults
	localparam int NUM_LANES = 2;
	localparam int CAP_DEPTH = 64;
	localparam int LED_HOLD  = 16;
	localparam int CLK_HALF  = 20;
	localparam int DRIVE_DLY = 2;

	typedef enum {OP_WRITE, OP_READ, OP_CORRUPT, OP_IDLE, OP_DUMP} op_t;

	logic                       CLK;
	logic                       rst_n_i;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	wb_addr_t                   wb_adr;
	wb_data_t                   wb_dat_w;
	wb_data_t                   wb_dat_r;
	logic                       wb_ack;
	lane_word_t [NUM_LANES-1:0] lane_tx;
	lane_word_t [NUM_LANES-1:0] lane_rx;
	lane_word_t [NUM_LANES-1:0] corrupt_mask;
	logic [NUM_LANES-1:0]       lane_tx_k;
	logic [NUM_LANES-1:0]       led;

	// Expected transmit word of every lane
	lane_word_t                 tx_model;

	// Stimulus table with one entry per row in each queue
	string    row_name[$];
	op_t      row_op[$];
	wb_addr_t row_addr[$];
	wb_data_t row_data[$];
	wb_data_t row_exp[$];
	int       row_lane[$];

	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 0;

	// External loopback where the corrupt mask flips bits in transit
	assign lane_rx = lane_tx ^ corrupt_mask;

	link_test_top i_link_test_top (
		.CLK         (CLK),
		.rst_n_i     (rst_n_i),
		.wb_cyc_i    (wb_cyc),
		.wb_stb_i    (wb_stb),
		.wb_we_i     (wb_we),
		.wb_adr_i    (wb_adr),
		.wb_dat_i    (wb_dat_w),
		.wb_dat_o    (wb_dat_r),
		.wb_ack_o    (wb_ack),
		.lane_tx_o   (lane_tx),
		.lane_tx_k_o (lane_tx_k),
		.lane_rx_i   (lane_rx),
		.led_o       (led)
	);

	initial begin
		CLK = 1'b0;
		forever #CLK_HALF CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting and bus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic compare_value(input string name, input wb_data_t expected,
		input wb_data_t actual);
		if (expected !== actual) begin
			stop_with_failure($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
				name, expected, actual));
		end
	endtask

	// Single classic cycle that returns one clock after the ack
	task automatic wb_transfer(input logic we, input wb_addr_t addr, input wb_data_t data,
		output wb_data_t rdata);
		int waits;
		waits    = 1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = addr;
		wb_dat_w = data;
		@(posedge CLK);
		#DRIVE_DLY;
		while (!wb_ack) begin
			waits++;
			@(posedge CLK);
			#DRIVE_DLY;
		end
		// Ack must follow the request edge directly
		compare_value("ack latency", 32'd1, wb_data_t'(waits));
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		// Next request then sees ack low
		@(posedge CLK);
		#DRIVE_DLY;
	endtask

	// Wait for done and check that every word is its predecessor plus one
	task automatic dump_capture(input string name, input int lane);
		wb_data_t   status;
		wb_data_t   word;
		lane_word_t prev;
		wb_addr_t   base;
		status = '0;
		prev   = '0;
		base   = wb_addr_t'(ADDR_CAP_BASE + 12'h100 * lane);
		while (status[lane] !== 1'b1) begin
			wb_transfer(1'b0, ADDR_STATUS, '0, status);
		end
		for (int i = 0; i < CAP_DEPTH; i++) begin
			wb_transfer(1'b0, wb_addr_t'(base + 4 * i), '0, word);
			if (i > 0) begin
				compare_value($sformatf("%s word %0d", name, i),
					{16'h0000, lane_word_t'(prev + 16'd1)}, word);
			end
			prev = word[15:0];
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Table
	////////////////////////////////////////////////////////////////////////////

	task automatic add_row(input string name, input op_t op, input wb_addr_t addr,
		input wb_data_t data, input wb_data_t exp, input int lane);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_exp.push_back(exp);
		row_lane.push_back(lane);
	endtask

	task automatic load_table();
		wb_addr_t cnt1;
		cnt1 = wb_addr_t'(ADDR_ERRCNT_BASE + 12'h4);
		// Reset state
		add_row("reset ctrl", OP_READ, ADDR_CTRL, '0, 32'h0, 0);
		add_row("reset status", OP_READ, ADDR_STATUS, '0, 32'h0, 0);
		add_row("reset count 0", OP_READ, ADDR_ERRCNT_BASE, '0, 32'h0, 0);
		add_row("reset count 1", OP_READ, cnt1, '0, 32'h0, 1);
		add_row("reset leds", OP_IDLE, '0, 32'd1, 32'h0, 0);
		// Register access also arms lane 0 once
		add_row("ctrl write", OP_WRITE, ADDR_CTRL, 32'h1, '0, 0);
		add_row("ctrl readback", OP_READ, ADDR_CTRL, '0, 32'h1, 0);
		add_row("unmapped write", OP_WRITE, 12'h00C, 32'hFFFF_FFFF, '0, 0);
		add_row("ctrl after unmapped", OP_READ, ADDR_CTRL, '0, 32'h1, 0);
		add_row("unmapped 0x008", OP_READ, 12'h008, '0, 32'h0, 0);
		add_row("count of lane 2", OP_READ, 12'h018, '0, 32'h0, 0);
		add_row("unmapped 0x400", OP_READ, 12'h400, '0, 32'h0, 0);
		add_row("ctrl clear", OP_WRITE, ADDR_CTRL, 32'h0, '0, 0);
		// Clean loopback
		add_row("clean idle", OP_IDLE, '0, 32'd200, 32'h0, 0);
		add_row("clean count 0", OP_READ, ADDR_ERRCNT_BASE, '0, 32'h0, 0);
		add_row("clean count 1", OP_READ, cnt1, '0, 32'h0, 1);
		// One bad word on lane 1
		add_row("corrupt lane 1", OP_CORRUPT, '0, 32'h0040, '0, 1);
		add_row("led on", OP_IDLE, '0, 32'd1, 32'h2, 0);
		// Lane 0 done from the first arm and LED bit of lane 1
		add_row("status led on", OP_READ, ADDR_STATUS, '0, 32'h0002_0001, 0);
		// Status read used two clocks of the hold window
		add_row("led last cycle", OP_IDLE, '0, wb_data_t'(LED_HOLD - 2), 32'h2, 0);
		add_row("led off", OP_IDLE, '0, 32'd1, 32'h0, 0);
		add_row("status led off", OP_READ, ADDR_STATUS, '0, 32'h0000_0001, 0);
		add_row("count 0 untouched", OP_READ, ADDR_ERRCNT_BASE, '0, 32'h0, 0);
		add_row("count 1 two errors", OP_READ, cnt1, '0, 32'h2, 1);
		add_row("count 1 clear", OP_WRITE, cnt1, 32'hFFFF, '0, 1);
		add_row("count 1 cleared", OP_READ, cnt1, '0, 32'h0, 1);
		// Capture
		add_row("arm lane 0", OP_WRITE, ADDR_CTRL, 32'h1, '0, 0);
		add_row("capture lane 0", OP_DUMP, '0, '0, '0, 0);
		add_row("rearm low", OP_WRITE, ADDR_CTRL, 32'h0, '0, 0);
		add_row("rearm high", OP_WRITE, ADDR_CTRL, 32'h1, '0, 0);
		add_row("done cleared", OP_READ, ADDR_STATUS, '0, 32'h0, 0);
	endtask

	// Sum of waits plus 4 per access and 64 per capture fill with some margin
	function automatic int unsigned cycle_budget();
		int unsigned total;
		total = 100;
		foreach (row_op[r]) begin
			case (row_op[r])
				OP_IDLE: total += row_data[r];
				OP_DUMP: total += 64 + 4 * CAP_DEPTH;
				default: total += 4;
			endcase
		end
		return total;
	endfunction

	task automatic run_row(input int r);
		wb_data_t rdata;
		case (row_op[r])
			OP_WRITE: wb_transfer(1'b1, row_addr[r], row_data[r], rdata);
			OP_READ: begin
				wb_transfer(1'b0, row_addr[r], '0, rdata);
				compare_value(row_name[r], row_exp[r], rdata);
			end
			OP_CORRUPT: begin
				// Bad word for exactly one clock
				corrupt_mask[row_lane[r]] = row_data[r][15:0];
				@(posedge CLK);
				#DRIVE_DLY;
				corrupt_mask = '0;
			end
			OP_IDLE: begin
				repeat (row_data[r]) begin
					@(posedge CLK);
					#DRIVE_DLY;
				end
				compare_value(row_name[r], row_exp[r], wb_data_t'(led));
			end
			default: dump_capture(row_name[r], row_lane[r]);
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Transmit stream monitor
	////////////////////////////////////////////////////////////////////////////

	// Word 0 in the first cycle out of reset, then one up per clock
	always @(negedge CLK) begin
		if (!rst_n_i) begin
			tx_model = '0;
		end else begin
			for (int n = 0; n < NUM_LANES; n++) begin
				compare_value($sformatf("tx word lane %0d", n),
					wb_data_t'(tx_model), wb_data_t'(lane_tx[n]));
				// Comma flag whenever the low byte is the comma character
				compare_value($sformatf("tx comma lane %0d", n),
					wb_data_t'(tx_model[7:0] == COMMA_CHAR), wb_data_t'(lane_tx_k[n]));
			end
			tx_model = lane_word_t'(tx_model + 16'd1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK) begin
		cycle_cnt = cycle_cnt + 1;
		if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit)) begin
			stop_with_failure("Timeout: the run hung waiting for the DUT");
		end
	end

	initial begin
		rst_n_i      = 1'b0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		corrupt_mask = '0;
		load_table();
		cycle_limit = cycle_budget();
		repeat (5) @(posedge CLK);
		#DRIVE_DLY;
		rst_n_i = 1'b1;
		foreach (row_op[r]) begin
			run_row(r);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
verilog/link_test_pkg.sv
verilog/lane_pattern_gen.sv
verilog/lane_checker.sv
verilog/capture_ram.sv
verilog/led_stretch.sv
verilog/link_regs.sv
verilog/link_test_top.sv
sim/tb_link_test.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the link test simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_link_test -f project.f

sim_out=$(./obj_dir/Vtb_link_test 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "PASS: all tests"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
